// ==== vlane_params.svh ====
// Widths and lane count for the four-lane vector datapath
// Shared by the type package and every datapath block

`ifndef VLANE_PARAMS_SVH
`define VLANE_PARAMS_SVH

// ------------------------------
// Lane geometry
// ------------------------------

// One lane word
`define VLANE_XLEN 32

// Lanes in one vector with lane 0 in the low bits
`define VLANE_LANES 4

// ------------------------------
// Register addressing
// ------------------------------

// Destination register number
`define VLANE_REG_AW 5

`endif

// ==== vlane_pkg.sv ====
// Types for the vector lane datapath
// Lane vectors, select encodings and the control that rides with each operation

`include "vlane_params.svh"

package vlane_pkg;

  typedef logic [`VLANE_XLEN-1:0] word_t;
  typedef logic [`VLANE_LANES*`VLANE_XLEN-1:0] vec_t;
  typedef logic [`VLANE_REG_AW-1:0] reg_addr_t;

  // ------------------------------
  // Select and function encodings
  // ------------------------------

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_fn_e;

  // Scalar is broadcast to every lane
  typedef enum logic [1:0] {OP_VEC, OP_SCALAR, OP_ZERO} op_sel_e;

  typedef enum logic [2:0] {LD_W, LD_B, LD_BU, LD_H, LD_HU} load_type_e;

  typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

  // ------------------------------
  // Control words
  // ------------------------------

  // Everything one operation needs as sampled at issue
  typedef struct packed {
    op_sel_e    op0_sel;
    op_sel_e    op1_sel;
    alu_fn_e    alu_fn;
    load_type_e load_type;
    wb_sel_e    wb_sel;
    logic       wen;
    reg_addr_t  waddr;
  } issue_ctrl_t;

  // Operand selects and ALU function are spent by the end of X
  typedef struct packed {
    load_type_e load_type;
    wb_sel_e    wb_sel;
    logic       wen;
    reg_addr_t  waddr;
  } stage_ctrl_t;

endpackage

// ==== vlane_operand_issue.sv ====
// Operand issue for the vector lanes
// Picks each operand from the lane vector, a broadcast scalar or zero, then registers into X

`timescale 1ns/1ps

`include "vlane_params.svh"

module vlane_operand_issue
  import vlane_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        stall,

  input  issue_ctrl_t issue,
  input  vec_t        vsrc0,
  input  vec_t        vsrc1,
  input  word_t       scalar,

  output vec_t        x_op0,
  output vec_t        x_op1,
  output vec_t        x_store_data,
  output issue_ctrl_t x_ctrl
);

  vec_t op0_d;
  vec_t op1_d;

  // ------------------------------
  // Operand select
  // ------------------------------

  function automatic vec_t pick_operand(op_sel_e sel, vec_t lane_vec, word_t bcast);
    vec_t result;
    case (sel)
      OP_VEC:    result = lane_vec;
      OP_SCALAR: result = {`VLANE_LANES{bcast}};
      default:   result = '0;
    endcase
    return result;
  endfunction

  assign op0_d = pick_operand(issue.op0_sel, vsrc0, scalar);
  assign op1_d = pick_operand(issue.op1_sel, vsrc1, scalar);

  // ------------------------------
  // X <- D
  // ------------------------------

  // Store data is always the second source vector
  always_ff @(posedge clk) begin
    if (!stall) begin
      x_op0        <= op0_d;
      x_op1        <= op1_d;
      x_store_data <= vsrc1;
    end
  end

  // Control into X with the write enable cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      x_ctrl.wen <= 1'b0;
    end else if (!stall) begin
      x_ctrl <= issue;
    end
  end

endmodule

// ==== vlane_execute.sv ====
// Execute stage for the vector lanes
// One ALU per lane, memory request out of X, and the X-to-M register

`timescale 1ns/1ps

`include "vlane_params.svh"

module vlane_execute
  import vlane_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        stall,

  input  vec_t        x_op0,
  input  vec_t        x_op1,
  input  vec_t        x_store_data,
  input  issue_ctrl_t x_ctrl,

  // Request leaves while the operation sits in X
  output vec_t        dmem_addr,
  output vec_t        dmem_store_data,

  output vec_t        m_alu_out,
  output stage_ctrl_t m_ctrl
);

  vec_t        alu_out;
  stage_ctrl_t x_stage_ctrl;

  // ------------------------------
  // Lane ALU
  // ------------------------------

  function automatic word_t lane_alu(alu_fn_e fn, word_t a, word_t b);
    logic [4:0] shamt;
    word_t      result;
    shamt = b[4:0];
    case (fn)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = word_t'($signed(a) < $signed(b));
      ALU_SLTU: result = word_t'(a < b);
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
    return result;
  endfunction

  // Every lane runs the same function on its own slice
  for (genvar lane = 0; lane < `VLANE_LANES; lane++) begin : g_lane
    word_t lane_a;
    word_t lane_b;

    assign lane_a = x_op0[lane*`VLANE_XLEN +: `VLANE_XLEN];
    assign lane_b = x_op1[lane*`VLANE_XLEN +: `VLANE_XLEN];

    assign alu_out[lane*`VLANE_XLEN +: `VLANE_XLEN] = lane_alu(x_ctrl.alu_fn, lane_a, lane_b);
  end

  // ------------------------------
  // Memory request
  // ------------------------------

  // Per-lane address is the lane's ALU result
  assign dmem_addr       = alu_out;
  assign dmem_store_data = x_store_data;

  // Drop the fields that are used up in X
  assign x_stage_ctrl = '{
    load_type: x_ctrl.load_type,
    wb_sel:    x_ctrl.wb_sel,
    wen:       x_ctrl.wen,
    waddr:     x_ctrl.waddr
  };

  // ------------------------------
  // M <- X
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!stall) begin
      m_alu_out <= alu_out;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      m_ctrl.wen <= 1'b0;
    end else if (!stall) begin
      m_ctrl <= x_stage_ctrl;
    end
  end

endmodule

// ==== vlane_load_writeback.sv ====
// Load extraction and writeback for the vector lanes
// Subword load per lane, ALU or memory select in M, then the X2, X3 and W registers

`timescale 1ns/1ps

`include "vlane_params.svh"

module vlane_load_writeback
  import vlane_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        stall,

  input  vec_t        m_alu_out,
  input  stage_ctrl_t m_ctrl,
  // Response for the operation in M
  input  vec_t        dmem_resp_data,

  output logic        wb_en,
  output reg_addr_t   wb_addr,
  output vec_t        wb_data
);

  // X2, X3 and W in that order
  localparam int WB_STAGES = 3;

  vec_t load_data;
  vec_t m_wb_data;

  vec_t                 pipe_data  [WB_STAGES];
  reg_addr_t            pipe_waddr [WB_STAGES];
  logic [WB_STAGES-1:0] pipe_wen;

  // ------------------------------
  // Load extraction
  // ------------------------------

  function automatic word_t extract_load(load_type_e ltype, word_t raw);
    word_t result;
    case (ltype)
      LD_B:    result = {{(`VLANE_XLEN-8){raw[7]}}, raw[7:0]};
      LD_BU:   result = {{(`VLANE_XLEN-8){1'b0}}, raw[7:0]};
      LD_H:    result = {{(`VLANE_XLEN-16){raw[15]}}, raw[15:0]};
      LD_HU:   result = {{(`VLANE_XLEN-16){1'b0}}, raw[15:0]};
      default: result = raw;
    endcase
    return result;
  endfunction

  for (genvar lane = 0; lane < `VLANE_LANES; lane++) begin : g_lane
    assign load_data[lane*`VLANE_XLEN +: `VLANE_XLEN] =
      extract_load(m_ctrl.load_type, dmem_resp_data[lane*`VLANE_XLEN +: `VLANE_XLEN]);
  end

  // Writeback mux, same choice for all lanes
  assign m_wb_data = (m_ctrl.wb_sel == WB_MEM) ? load_data : m_alu_out;

  // ------------------------------
  // X2 <- M, X3 <- X2, W <- X3
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!stall) begin
      pipe_data[0]  <= m_wb_data;
      pipe_waddr[0] <= m_ctrl.waddr;
      for (int s = 1; s < WB_STAGES; s++) begin
        pipe_data[s]  <= pipe_data[s-1];
        pipe_waddr[s] <= pipe_waddr[s-1];
      end
    end
  end

  // Write enables shift up one stage per edge
  always_ff @(posedge clk) begin
    if (reset) begin
      pipe_wen <= '0;
    end else if (!stall) begin
      pipe_wen <= {pipe_wen[WB_STAGES-2:0], m_ctrl.wen};
    end
  end

  // ------------------------------
  // Writeback outputs
  // ------------------------------

  assign wb_en   = pipe_wen[WB_STAGES-1];
  assign wb_addr = pipe_waddr[WB_STAGES-1];
  assign wb_data = pipe_data[WB_STAGES-1];

endmodule

// ==== vlane_dpath.sv ====
// Four-lane vector datapath top
// Operand issue, execute with memory request, then load and writeback

`timescale 1ns/1ps

module vlane_dpath
  import vlane_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  // Freezes every stage register
  input  logic        stall,

  input  issue_ctrl_t issue,
  input  vec_t        vsrc0,
  input  vec_t        vsrc1,
  input  word_t       scalar,

  output vec_t        dmem_addr,
  output vec_t        dmem_store_data,
  input  vec_t        dmem_resp_data,

  output logic        wb_en,
  output reg_addr_t   wb_addr,
  output vec_t        wb_data
);

  // X stage
  vec_t        x_op0;
  vec_t        x_op1;
  vec_t        x_store_data;
  issue_ctrl_t x_ctrl;

  // M stage
  vec_t        m_alu_out;
  stage_ctrl_t m_ctrl;

  vlane_operand_issue u_issue (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .issue        (issue),
    .vsrc0        (vsrc0),
    .vsrc1        (vsrc1),
    .scalar       (scalar),
    .x_op0        (x_op0),
    .x_op1        (x_op1),
    .x_store_data (x_store_data),
    .x_ctrl       (x_ctrl)
  );

  vlane_execute u_execute (
    .clk             (clk),
    .reset           (reset),
    .stall           (stall),
    .x_op0           (x_op0),
    .x_op1           (x_op1),
    .x_store_data    (x_store_data),
    .x_ctrl          (x_ctrl),
    .dmem_addr       (dmem_addr),
    .dmem_store_data (dmem_store_data),
    .m_alu_out       (m_alu_out),
    .m_ctrl          (m_ctrl)
  );

  vlane_load_writeback u_load_wb (
    .clk            (clk),
    .reset          (reset),
    .stall          (stall),
    .m_alu_out      (m_alu_out),
    .m_ctrl         (m_ctrl),
    .dmem_resp_data (dmem_resp_data),
    .wb_en          (wb_en),
    .wb_addr        (wb_addr),
    .wb_data        (wb_data)
  );

endmodule

// ==== tb_clock_gen.sv ====
// Clock and reset source for the datapath testbench
// 40 ns clock with reset held for the first two rising edges

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== vlane_dpath_assertions.sv ====
// Writeback checks for the vector lane datapath
// Bound into the top level to watch wb_en and wb_data around reset and stalls

`timescale 1ns/1ps

`include "vlane_params.svh"

module vlane_dpath_assertions
  import vlane_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic stall,
  input logic wb_en,
  input vec_t wb_data
);

  // ------------------------------
  // Writeback enable
  // ------------------------------

  a_wb_en_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(wb_en)
  ) else $error("wb_en is unknown after reset");

  // Cleared by reset in every stage
  a_wb_en_after_reset: assert property (
    @(posedge clk) reset |=> !wb_en
  ) else $error("wb_en high in the cycle after reset");

  // ------------------------------
  // Stall hold
  // ------------------------------

  a_stall_hold: assert property (
    @(posedge clk) disable iff (reset)
      stall |=> ($stable(wb_data) && $stable(wb_en))
  ) else $error("writeback outputs moved across a stalled edge");

endmodule

// ==== tb_vlane_dpath.sv ====
// Testbench for the four-lane vector datapath
// Replays operations from the stimulus file against a lane memory model

`timescale 1ns/1ps

`include "vlane_params.svh"

module tb_vlane_dpath
  import vlane_pkg::*;
();

  localparam int MAX_OPS      = 64;
  localparam int RAND_OPS     = 6;
  localparam int DRAIN_CYCLES = 8;
  localparam int CLK_PERIOD   = 40;

  logic        clk;
  logic        reset;
  logic        stall;
  issue_ctrl_t issue;
  vec_t        vsrc0;
  vec_t        vsrc1;
  word_t       scalar;
  vec_t        dmem_addr;
  vec_t        dmem_store_data;
  vec_t        dmem_resp_data;
  logic        wb_en;
  reg_addr_t   wb_addr;
  vec_t        wb_data;

  // Operation table with file lines first and the random scalar group after
  logic [8*24-1:0] op_name  [MAX_OPS];
  issue_ctrl_t     op_ctrl  [MAX_OPS];
  vec_t            op_vsrc0 [MAX_OPS];
  vec_t            op_vsrc1 [MAX_OPS];
  word_t           op_scalar[MAX_OPS];
  logic            op_stall [MAX_OPS];
  vec_t            op_exp   [MAX_OPS];
  int              n_ops;

  word_t  mem [16];
  vec_t   resp_addr;
  int     exp_q[$];
  logic   loaded;
  int     x_idx;
  int     pending_idx;
  logic   edge_stalled;
  logic   snap_en;
  reg_addr_t snap_addr;
  vec_t   snap_data;
  integer seed;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  vlane_dpath DUT (
    .clk             (clk),
    .reset           (reset),
    .stall           (stall),
    .issue           (issue),
    .vsrc0           (vsrc0),
    .vsrc1           (vsrc1),
    .scalar          (scalar),
    .dmem_addr       (dmem_addr),
    .dmem_store_data (dmem_store_data),
    .dmem_resp_data  (dmem_resp_data),
    .wb_en           (wb_en),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data)
  );

  bind vlane_dpath vlane_dpath_assertions u_assertions (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .wb_en   (wb_en),
    .wb_data (wb_data)
  );

  // ------------------------------
  // Memory model
  // ------------------------------

  // Address captured as the op leaves X
  always @(posedge clk) begin
    if (!stall) begin
      resp_addr <= dmem_addr;
    end
  end

  // Word index from address bits 5:2
  always_comb begin
    for (int l = 0; l < `VLANE_LANES; l++) begin
      dmem_resp_data[l*`VLANE_XLEN +: `VLANE_XLEN] = mem[resp_addr[l*`VLANE_XLEN+2 +: 4]];
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // Lane ALU rules for the random scalar group
  function automatic word_t ref_alu(alu_fn_e fn, word_t a, word_t b);
    logic [4:0] sh;
    word_t      r;
    sh = b[4:0];
    case (fn)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a + ~b + 32'd1;
      ALU_SLL:  r = a << sh;
      ALU_SLT:  r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      ALU_SLTU: r = {31'd0, a < b};
      ALU_XOR:  r = a ^ b;
      ALU_SRL:  r = a >> sh;
      ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0);
      ALU_OR:   r = a | b;
      default:  r = a & b;
    endcase
    return r;
  endfunction

  task automatic load_stimulus();
    int              fd;
    string           line;
    int              cnt;
    int              n_mem;
    word_t           word;
    logic [8*24-1:0] name;
    int              f_op0, f_op1, f_fn, f_ld, f_wb, f_wen, f_waddr, f_stall;
    vec_t            v0, v1, e;
    word_t           sc;
    issue_ctrl_t     ctrl;
    n_mem = 0;
    fd = $fopen("vlane_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("Cannot open vlane_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cnt = $fgets(line, fd);
        if (line.len() < 2 || line[0] == "#") continue;
        if (n_mem < 16) begin
          cnt = $sscanf(line, "%h", word);
          mem[n_mem] = word;
          n_mem++;
        end else begin
          cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %h %h %h %d %h", name, f_op0, f_op1,
                        f_fn, f_ld, f_wb, f_wen, f_waddr, v0, v1, sc, f_stall, e);
          if (cnt != 13) report_failure("Malformed operation line in stimulus file");
          ctrl           = '0;
          ctrl.op0_sel   = op_sel_e'(f_op0);
          ctrl.op1_sel   = op_sel_e'(f_op1);
          ctrl.alu_fn    = alu_fn_e'(f_fn);
          ctrl.load_type = load_type_e'(f_ld);
          ctrl.wb_sel    = wb_sel_e'(f_wb);
          ctrl.wen       = f_wen[0];
          ctrl.waddr     = reg_addr_t'(f_waddr);
          op_name[n_ops]   = name;
          op_ctrl[n_ops]   = ctrl;
          op_vsrc0[n_ops]  = v0;
          op_vsrc1[n_ops]  = v1;
          op_scalar[n_ops] = sc;
          op_stall[n_ops]  = f_stall[0];
          op_exp[n_ops]    = e;
          n_ops++;
        end
      end
      $fclose(fd);
      if (n_mem < 16) report_failure("Stimulus file holds fewer than 16 memory words");
    end
  endtask

  // Vector op0 against a broadcast random scalar
  task automatic add_random_ops();
    alu_fn_e     fn;
    issue_ctrl_t ctrl;
    vec_t        e;
    for (int r = 0; r < RAND_OPS; r++) begin
      case (r)
        0:       fn = ALU_ADD;
        1:       fn = ALU_SUB;
        2:       fn = ALU_SLT;
        3:       fn = ALU_SLTU;
        4:       fn = ALU_SRA;
        default: fn = ALU_SLL;
      endcase
      ctrl         = '0;
      ctrl.op0_sel = OP_VEC;
      ctrl.op1_sel = OP_SCALAR;
      ctrl.alu_fn  = fn;
      ctrl.wb_sel  = WB_ALU;
      ctrl.wen     = 1'b1;
      ctrl.waddr   = reg_addr_t'(23 + r);
      op_name[n_ops]   = "rand_scalar";
      op_ctrl[n_ops]   = ctrl;
      op_vsrc0[n_ops]  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      op_vsrc1[n_ops]  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      op_scalar[n_ops] = $random(seed);
      op_stall[n_ops]  = 1'b0;
      for (int l = 0; l < `VLANE_LANES; l++) begin
        e[l*`VLANE_XLEN +: `VLANE_XLEN] =
          ref_alu(fn, op_vsrc0[n_ops][l*`VLANE_XLEN +: `VLANE_XLEN], op_scalar[n_ops]);
      end
      op_exp[n_ops] = e;
      n_ops++;
    end
  endtask

  task automatic drive_idle();
    stall  <= 1'b0;
    issue  <= '0;
    vsrc0  <= '0;
    vsrc1  <= '0;
    scalar <= '0;
  endtask

  // ------------------------------
  // Checks at the falling edge
  // ------------------------------

  task automatic check_outputs();
    int idx;
    if (x_idx >= 0 && !edge_stalled) begin
      assert (dmem_store_data === op_vsrc1[x_idx])
        else report_failure($sformatf("Fail %0s store data expected %h actual %h",
                            op_name[x_idx], op_vsrc1[x_idx], dmem_store_data));
      if (op_ctrl[x_idx].wb_sel == WB_ALU) begin
        assert (dmem_addr === op_exp[x_idx])
          else report_failure($sformatf("Fail %0s dmem_addr expected %h actual %h",
                              op_name[x_idx], op_exp[x_idx], dmem_addr));
      end
    end
    assert (!$isunknown(wb_en))
      else report_failure("wb_en is unknown after reset");
    if (edge_stalled) begin
      assert (wb_en === snap_en && wb_addr === snap_addr && wb_data === snap_data)
        else report_failure("Writeback outputs changed across a stalled edge");
    end else if (wb_en) begin
      assert (exp_q.size() > 0)
        else report_failure("wb_en went high with no enabled operation in flight");
      idx = exp_q.pop_front();
      assert (wb_data === op_exp[idx])
        else report_failure($sformatf("Fail %0s wb_data expected %h actual %h",
                            op_name[idx], op_exp[idx], wb_data));
      assert (wb_addr === op_ctrl[idx].waddr)
        else report_failure($sformatf("Fail %0s wb_addr expected %h actual %h",
                            op_name[idx], op_ctrl[idx].waddr, wb_addr));
    end
    snap_en   = wb_en;
    snap_addr = wb_addr;
    snap_data = wb_data;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    stall       = 1'b0;
    issue       = '0;
    vsrc0       = '0;
    vsrc1       = '0;
    scalar      = '0;
    n_ops       = 0;
    loaded      = 1'b0;
    x_idx       = -1;
    pending_idx = -1;
    seed        = 32'h8e79d799;
    load_stimulus();
    add_random_ops();
    loaded = 1'b1;

    while (reset !== 1'b0) @(negedge clk);

    // Reset has just cleared every write enable
    assert (wb_en === 1'b0)
      else report_failure("wb_en is not low right after reset");

    for (int i = 0; i < n_ops + DRAIN_CYCLES; i++) begin
      @(posedge clk);
      // Stall level sampled by the DUT at this edge
      edge_stalled = stall;
      if (!edge_stalled) x_idx = pending_idx;
      if (i < n_ops) begin
        stall  <= op_stall[i];
        issue  <= op_ctrl[i];
        vsrc0  <= op_vsrc0[i];
        vsrc1  <= op_vsrc1[i];
        scalar <= op_scalar[i];
        pending_idx = op_stall[i] ? -1 : i;
        if (!op_stall[i] && op_ctrl[i].wen) exp_q.push_back(i);
      end else begin
        drive_idle();
        pending_idx = -1;
      end
      @(negedge clk);
      check_outputs();
    end

    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d results never reached writeback", exp_q.size()));
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  // Watchdog sized from the operation count
  initial begin
    wait (loaded);
    #((n_ops + 20) * CLK_PERIOD);
    report_failure("Timeout, simulation ran past the expected length");
  end

endmodule

// ==== vlane_dpath.f ====
+incdir+.
vlane_pkg.sv
vlane_operand_issue.sv
vlane_execute.sv
vlane_load_writeback.sv
vlane_dpath.sv
tb_clock_gen.sv
vlane_dpath_assertions.sv
tb_vlane_dpath.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector lane datapath testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  --top-module tb_vlane_dpath \
  -f vlane_dpath.f \
  -o sim_vlane_dpath
./obj_dir/sim_vlane_dpath

// ==== vlane_stimulus.txt ====
# First 16 data lines: memory words 0..15 (hex)
# Then: name op0 op1 fn ld wb wen waddr vsrc0 vsrc1 scalar stall expected_wb_data
11223344
8899aabb
7f80ff01
deadbeef
0000807f
12345678
fedcba98
00ff00ff
80000001
7fffffff
55aa55aa
a55aa55a
0badf00d
cafe8001
00000080
ffff7fff
nowen_add 0 0 0 0 0 0 1 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 80000001fffffff40000000012345687
vv_add 0 0 0 0 0 1 1 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 80000001fffffff40000000012345687
vv_sub 0 0 1 0 0 1 2 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 7fffffffffffffec0000000a12345669
stall 0 0 0 0 0 0 0 0 0 0 1 0
vv_sll 0 0 2 0 0 1 3 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 00000000ffffff00280000002b3c0000
vv_slt 0 0 3 0 0 1 4 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 00000001000000010000000000000000
stall 0 0 0 0 0 0 0 0 0 0 1 0
stall 0 0 0 0 0 0 0 0 0 0 1 0
vv_sltu 0 0 4 0 0 1 5 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 00000000000000000000000100000000
vv_xor 0 0 5 0 0 1 6 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 80000001fffffff4fffffffe12345677
vv_srl 0 0 6 0 0 1 7 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 400000000fffffff0000000000002468
stall 0 0 0 0 0 0 0 0 0 0 1 0
vv_sra 0 0 7 0 0 1 8 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 c0000000ffffffff0000000000002468
vv_or 0 0 8 0 0 1 9 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 80000001fffffff4ffffffff1234567f
vv_and 0 0 9 0 0 1 10 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 00000000000000000000000100000008
sel_scalar_op0 1 0 0 0 0 1 11 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 0000abcd 0 0000abce0000abd10000abc80000abdc
sel_scalar_op1 0 1 5 0 0 1 12 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 0000abcd 0 8000abcdffff543d0000abc81234fdb5
sel_zero_op0 2 0 1 0 0 1 13 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 0000abcd 0 fffffffffffffffc00000005fffffff1
sel_zero_op1 0 2 8 0 0 1 14 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 0000abcd 0 80000000fffffff00000000512345678
sel_scalar_both 1 1 0 0 0 1 15 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 0000abcd 0 0001579a0001579a0001579a0001579a
nowen_xor 0 0 5 0 0 0 31 80000000fffffff00000000512345678 0000000100000004fffffffb0000000f 00000000 0 80000001fffffff4fffffffe12345677
ld_w 0 2 0 0 1 1 16 00000034000000100000000c00000004 0000000100000004fffffffb0000000f 00000000 0 cafe80010000807fdeadbeef8899aabb
ld_b 0 2 0 1 1 1 17 00000034000000100000000c00000004 0000000100000004fffffffb0000000f 00000000 0 000000010000007fffffffefffffffbb
stall 0 0 0 0 0 0 0 0 0 0 1 0
ld_bu 0 2 0 2 1 1 18 00000034000000100000000c00000004 0000000100000004fffffffb0000000f 00000000 0 000000010000007f000000ef000000bb
ld_h 0 2 0 3 1 1 19 00000034000000100000000c00000004 0000000100000004fffffffb0000000f 00000000 0 ffff8001ffff807fffffbeefffffaabb
ld_hu 0 2 0 4 1 1 20 00000034000000100000000c00000004 0000000100000004fffffffb0000000f 00000000 0 000080010000807f0000beef0000aabb
ld_b_offset 0 1 0 1 1 1 21 00000034000000300000001000000000 a55aa55a0badf00d1122334455667788 00000008 0 ffffffffffffff80ffffff9800000001
ld_h_offset 0 1 0 3 1 1 22 00000034000000300000001000000000 a55aa55a0badf00d1122334455667788 00000008 0 00007fff00000080ffffba98ffffff01
